//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module tb_xdata_engine -f xdata_engine.f \
      -o sim_xdata_engine > build.log 2>&1; then
   cat build.log
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/sim_xdata_engine > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi

exit 0

//--- tb_xdata_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_xdata_engine;
   import xdata_pkg::*;
   import xconf_pkg::*;

   logic     rst_reg;
   logic     clk;
   logic     in_we;
   data_t    in_a;
   data_t    in_b;
   logic     conf_we;
   logic     conf_addr;
   fu_conf_t conf_wdata;
   logic     conf_update;
   data_t    mul_result;
   data_t    alu_result;

   // cycle model state
   data_t    m_a;
   data_t    m_b;
   data_t    m_mul_res;
   data_t    m_alu_res;
   data_t    m_mul_opa;
   data_t    m_mul_opb;
   data_t    m_alu_opa;
   data_t    m_alu_opb;
   prod_t    m_prod;
   data_t    m_cur [4];
   data_t    m_prev [4];
   fu_conf_t m_shadow [2];
   fu_conf_t m_active [2];

   logic [31:0] lfsr_state;
   int   checks = 0;
   int   errors = 0;
   int   tests = 0;
   int   done_checks = 0;
   int   done_errors = 0;
   logic timed_out = 1'b0;
   logic check_prev = 1'b0;

   xdata_engine i_xdata_engine (
      .rst_reg     (rst_reg),
      .clk         (clk),
      .in_we       (in_we),
      .in_a        (in_a),
      .in_b        (in_b),
      .conf_we     (conf_we),
      .conf_addr   (conf_addr),
      .conf_wdata  (conf_wdata),
      .conf_update (conf_update),
      .mul_result  (mul_result),
      .alu_result  (alu_result)
   );

   initial begin
      rst_reg = 1'b0;
      forever #2 rst_reg = ~rst_reg;
   end

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         // galois step with taps 32 30 26 25
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA300_0000 : lfsr_state >> 1;
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic data_t rand_word();
      return data_t'(rand_bits(32));
   endfunction

   function automatic logic rand_bit();
      return rand_bits(1) != 0;
   endfunction

   // word is sela | selb | fn
   function automatic fu_conf_t conf_word(sel_t a, sel_t b, logic [2:0] fn);
      return {a, b, fn};
   endfunction

   function automatic logic both_valid(fu_conf_t c);
      return !c[10] && !c[6];
   endfunction

   function automatic data_t pick(sel_t s);
      if (s[3])
         return '0;
      if (s[2])
         return m_prev[s[1:0]];
      return m_cur[s[1:0]];
   endfunction

   function automatic data_t mul_window(prod_t p, logic [2:0] fn);
      case (fn)
         MUL_HI:      return p[62:31];
         MUL_DIV2_HI: return p[63:32];
         default:     return p[31:0];
      endcase
   endfunction

   function automatic data_t alu_model(data_t a, data_t b, logic [2:0] fn);
      case (fn)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_MAX: return (a > b) ? a : b;
         ALU_MIN: return (a < b) ? a : b;
         default: return a;
      endcase
   endfunction

   task automatic model_reset();
      m_a = '0;
      m_b = '0;
      m_mul_res = '0;
      m_alu_res = '0;
      m_mul_opa = '0;
      m_mul_opb = '0;
      m_alu_opa = '0;
      m_alu_opb = '0;
      m_prod = '0;
      foreach (m_prev[i]) m_prev[i] = '0;
      foreach (m_shadow[i]) begin
         m_shadow[i] = '0;
         m_active[i] = conf_word(SEL_NONE, SEL_NONE, 3'd0);
      end
   endtask

   task automatic model_step();
      fu_conf_t mc;
      fu_conf_t ac;
      fu_conf_t mul_next;
      fu_conf_t alu_next;
      mc = m_active[0];
      ac = m_active[1];
      m_cur[0] = m_a;
      m_cur[1] = m_b;
      m_cur[2] = m_mul_res;
      m_cur[3] = m_alu_res;
      // later stages first so each reads the old value of the one before
      if (both_valid(mc))
         m_mul_res = mul_window(m_prod, mc[2:0]);
      m_prod = prod_t'(m_mul_opa) * prod_t'(m_mul_opb);
      m_mul_opa = pick(mc[10:7]);
      m_mul_opb = pick(mc[6:3]);
      if (both_valid(ac))
         m_alu_res = alu_model(m_alu_opa, m_alu_opb, ac[2:0]);
      m_alu_opa = pick(ac[10:7]);
      m_alu_opb = pick(ac[6:3]);
      foreach (m_prev[i]) m_prev[i] = m_cur[i];
      if (in_we) begin
         m_a = in_a;
         m_b = in_b;
      end
      mul_next = (conf_we && !conf_addr) ? conf_wdata : m_shadow[0];
      alu_next = (conf_we && conf_addr) ? conf_wdata : m_shadow[1];
      m_shadow[0] = mul_next;
      m_shadow[1] = alu_next;
      if (conf_update) begin
         m_active[0] = mul_next;
         m_active[1] = alu_next;
      end
   endtask

   task automatic check_word(string name, data_t got, data_t exp);
      checks++;
      assert (got == exp) else begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_outputs();
      bus_t prev_exp;
      check_word("mul_result", mul_result, m_mul_res);
      check_word("alu_result", alu_result, m_alu_res);
      if (check_prev) begin
         prev_exp = {m_prev[3], m_prev[2], m_prev[1], m_prev[0]};
         checks++;
         assert (i_xdata_engine.data_bus_prev == prev_exp) else begin
            $display("Fail data_bus_prev: got %h expected %h",
                     i_xdata_engine.data_bus_prev, prev_exp);
            errors++;
         end
      end
   endtask

   // one clock, model and compare, then strobes drop
   task automatic step_cycle();
      @(posedge rst_reg);
      if (clk)
         model_reset();
      else
         model_step();
      #0.25;
      check_outputs();
      #0.25;
      in_we = 1'b0;
      conf_we = 1'b0;
      conf_update = 1'b0;
   endtask

   task automatic apply_conf(logic addr, fu_conf_t word, logic update);
      conf_we = 1'b1;
      conf_addr = addr;
      conf_wdata = word;
      conf_update = update;
      step_cycle();
   endtask

   task automatic load_operands(data_t a, data_t b);
      in_we = 1'b1;
      in_a = a;
      in_b = b;
      step_cycle();
   endtask

   task automatic wait_mul_value(data_t exp, int limit);
      int n;
      n = 0;
      while (mul_result != exp && n < limit) begin
         step_cycle();
         n++;
      end
      if (mul_result != exp) begin
         $display("timeout: multiplier result did not reach %h in %0d cycles", exp, limit);
         timed_out = 1'b1;
      end
   endtask

   task automatic test_done(string name);
      $display("test %s done: %0d checks, %0d errors", name,
               checks - done_checks, errors - done_errors);
      tests++;
      done_checks = checks;
      done_errors = errors;
   endtask

   task automatic reset_hold();
      repeat (20) begin
         load_operands(rand_word(), rand_word());
         check_word("mul_result", mul_result, '0);
         check_word("alu_result", alu_result, '0);
      end
      test_done("reset");
   endtask

   task automatic mul_windows();
      apply_conf(UNIT_MUL, conf_word(4'd0, 4'd1, MUL_LO), 1'b1);
      load_operands(32'sd3, 32'sd5);
      wait_mul_value(32'sd15, 10);
      if (!timed_out) begin
         for (int f = 0; f < 3; f++) begin
            apply_conf(UNIT_MUL, conf_word(4'd0, 4'd1, f[2:0]), 1'b1);
            repeat (200) load_operands(rand_word(), rand_word());
         end
      end
      test_done("multiplier windows");
   endtask

   task automatic alu_functions();
      data_t a;
      data_t b;
      for (int f = 0; f < 8; f++) begin
         apply_conf(UNIT_ALU, conf_word(4'd0, 4'd1, f[2:0]), 1'b1);
         repeat (40) begin
            a = rand_word();
            b = rand_word();
            // equal and opposite sign pairs for max and min
            case (rand_bits(2))
               0: b = a;
               1: b = a ^ 32'h8000_0000;
               default: ;
            endcase
            load_operands(a, b);
         end
      end
      test_done("alu functions");
   endtask

   task automatic chaining();
      check_prev = 1'b1;
      apply_conf(UNIT_MUL, conf_word(4'd3, 4'd1, MUL_LO), 1'b0);
      apply_conf(UNIT_ALU, conf_word(4'd2, 4'd4, ALU_ADD), 1'b1);
      repeat (100) load_operands(rand_word(), rand_word());
      test_done("chaining");
   endtask

   task automatic staging();
      data_t hold_mul;
      data_t hold_alu;
      data_t x;
      apply_conf(UNIT_MUL, conf_word(4'd0, 4'd1, MUL_HI), 1'b0);
      apply_conf(UNIT_ALU, conf_word(4'd0, 4'd1, ALU_SUB), 1'b1);
      load_operands(rand_word(), rand_word());
      repeat (6) step_cycle();
      hold_mul = m_mul_res;
      hold_alu = m_alu_res;
      repeat (10) begin
         apply_conf(rand_bit(), fu_conf_t'(rand_bits(11)), 1'b0);
         check_word("mul_result", mul_result, hold_mul);
         check_word("alu_result", alu_result, hold_alu);
      end
      apply_conf(UNIT_MUL, conf_word(SEL_NONE, 4'd1, MUL_LO), 1'b0);
      apply_conf(UNIT_ALU, conf_word(4'd0, SEL_NONE, ALU_ADD), 1'b1);
      step_cycle();
      hold_mul = m_mul_res;
      hold_alu = m_alu_res;
      repeat (30) begin
         load_operands(rand_word(), rand_word());
         check_word("mul_result", mul_result, hold_mul);
         check_word("alu_result", alu_result, hold_alu);
      end
      x = rand_word();
      in_we = 1'b1;
      in_a = x;
      in_b = rand_word();
      apply_conf(UNIT_ALU, conf_word(4'd0, 4'd1, ALU_PASS), 1'b1);
      step_cycle();
      step_cycle();
      check_word("alu_result", alu_result, x);
      test_done("configuration staging");
   endtask

   task automatic random_mix();
      repeat (2000) begin
         in_we = rand_bit();
         in_a = rand_word();
         in_b = rand_word();
         conf_we = rand_bit();
         conf_addr = rand_bit();
         conf_wdata = fu_conf_t'(rand_bits(11));
         conf_update = rand_bits(2) == 0;
         step_cycle();
      end
      test_done("random mix");
   endtask

   initial begin
      lfsr_state = 32'd71770;
      clk = 1'b1;
      in_we = 1'b0;
      in_a = '0;
      in_b = '0;
      conf_we = 1'b0;
      conf_addr = 1'b0;
      conf_wdata = '0;
      conf_update = 1'b0;
      model_reset();
      repeat (10) step_cycle();
      clk = 1'b0;
      reset_hold();
      mul_windows();
      if (!timed_out) begin
         alu_functions();
         chaining();
         staging();
         random_mix();
      end
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && !timed_out)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- xalu.sv
`timescale 1ns/10ps
`default_nettype none

module xalu (
   input logic rst_reg,
   input logic clk,
   xfu_if.fu   fu
);
   import xdata_pkg::*;
   import xconf_pkg::*;

   data_t   op_a;
   data_t   op_b;
   data_t   op_a_reg;
   data_t   op_b_reg;
   data_t   res;
   logic    enablea;
   logic    enableb;
   logic    enabled;
   alu_fn_e fn;

   xinmux muxa (
      .sel           (conf_sela(fu.conf)),
      .data_bus      (fu.data_bus),
      .data_bus_prev (fu.data_bus_prev),
      .data_out      (op_a),
      .enabled       (enablea)
   );

   xinmux muxb (
      .sel           (conf_selb(fu.conf)),
      .data_bus      (fu.data_bus),
      .data_bus_prev (fu.data_bus_prev),
      .data_out      (op_b),
      .enabled       (enableb)
   );

   assign enabled = enablea & enableb;
   assign fn = alu_fn_e'(conf_fn(fu.conf));

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
      end else begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
      end
   end

   // signed compares for max and min
   always_comb begin
      res = op_a_reg;
      case (fn)
         ALU_ADD:  res = op_a_reg + op_b_reg;
         ALU_SUB:  res = op_a_reg - op_b_reg;
         ALU_AND:  res = op_a_reg & op_b_reg;
         ALU_OR:   res = op_a_reg | op_b_reg;
         ALU_XOR:  res = op_a_reg ^ op_b_reg;
         ALU_MAX:  res = (op_a_reg > op_b_reg) ? op_a_reg : op_b_reg;
         ALU_MIN:  res = (op_a_reg < op_b_reg) ? op_a_reg : op_b_reg;
         ALU_PASS: res = op_a_reg;
         default:  res = op_a_reg;
      endcase
   end

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk)
         fu.result <= '0;
      else if (enabled)
         fu.result <= res;
   end

   // active word comes from the configuration block
   a_fn_known: assert property (
      @(posedge rst_reg) disable iff (clk) enabled |-> !$isunknown(fn)
   );

endmodule

`default_nettype wire

//--- xconf_pkg.sv
`default_nettype none

package xconf_pkg;

   localparam int N_W = 4;
   localparam int FN_W = 3;
   localparam int CONF_W = 2*N_W + FN_W;

   typedef logic [N_W-1:0] sel_t;
   typedef logic [FN_W-1:0] fn_t;
   typedef logic [CONF_W-1:0] fu_conf_t;

   // 0..3 current bus, 4..7 previous bus, 8..15 none
   localparam sel_t SEL_NONE = sel_t'(8);

   // reset value of an active word
   localparam fu_conf_t CONF_NONE = {SEL_NONE, SEL_NONE, fn_t'(0)};

   // configuration addresses
   localparam logic UNIT_MUL = 1'b0;
   localparam logic UNIT_ALU = 1'b1;

   typedef enum logic [FN_W-1:0] {
      MUL_LO      = 3'd0,
      MUL_HI      = 3'd1,
      MUL_DIV2_HI = 3'd2
   } mul_fn_e;

   typedef enum logic [FN_W-1:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_MAX  = 3'd5,
      ALU_MIN  = 3'd6,
      ALU_PASS = 3'd7
   } alu_fn_e;

   // word layout is sela | selb | fn
   function automatic sel_t conf_sela(fu_conf_t c);
      return c[CONF_W-1 -: N_W];
   endfunction

   function automatic sel_t conf_selb(fu_conf_t c);
      return c[CONF_W-1-N_W -: N_W];
   endfunction

   function automatic fn_t conf_fn(fu_conf_t c);
      return c[FN_W-1:0];
   endfunction

endpackage

`default_nettype wire

//--- xconf_reg.sv
`timescale 1ns/10ps
`default_nettype none

module xconf_reg (
   input  logic                rst_reg,
   input  logic                clk,
   input  logic                conf_we,
   input  logic                conf_addr,
   input  xconf_pkg::fu_conf_t conf_wdata,
   input  logic                conf_update,
   output xconf_pkg::fu_conf_t mul_conf,
   output xconf_pkg::fu_conf_t alu_conf
);
   import xconf_pkg::*;

   fu_conf_t mul_shadow;
   fu_conf_t alu_shadow;
   fu_conf_t mul_next;
   fu_conf_t alu_next;

   // a write in the update cycle is forwarded
   assign mul_next = (conf_we && conf_addr == UNIT_MUL) ? conf_wdata : mul_shadow;
   assign alu_next = (conf_we && conf_addr == UNIT_ALU) ? conf_wdata : alu_shadow;

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         mul_shadow <= '0;
         alu_shadow <= '0;
      end else begin
         mul_shadow <= mul_next;
         alu_shadow <= alu_next;
      end
   end

   // both units switch on the same edge
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         mul_conf <= CONF_NONE;
         alu_conf <= CONF_NONE;
      end else if (conf_update) begin
         mul_conf <= mul_next;
         alu_conf <= alu_next;
      end
   end

   a_addr_known: assert property (
      @(posedge rst_reg) disable iff (clk) conf_we |-> !$isunknown(conf_addr)
   );

endmodule

`default_nettype wire

//--- xdata_bus.sv
`timescale 1ns/10ps
`default_nettype none

module xdata_bus (
   input  logic             rst_reg,
   input  logic             clk,
   input  logic             in_we,
   input  xdata_pkg::data_t in_a,
   input  xdata_pkg::data_t in_b,
   input  xdata_pkg::data_t mul_result,
   input  xdata_pkg::data_t alu_result,
   output xdata_pkg::bus_t  data_bus,
   output xdata_pkg::bus_t  data_bus_prev
);
   import xdata_pkg::*;

   data_t in_a_reg;
   data_t in_b_reg;

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         in_a_reg <= '0;
         in_b_reg <= '0;
      end else if (in_we) begin
         in_a_reg <= in_a;
         in_b_reg <= in_b;
      end
   end

   assign data_bus[ENTRY_A*DATA_W +: DATA_W] = in_a_reg;
   assign data_bus[ENTRY_B*DATA_W +: DATA_W] = in_b_reg;
   assign data_bus[ENTRY_MUL*DATA_W +: DATA_W] = mul_result;
   assign data_bus[ENTRY_ALU*DATA_W +: DATA_W] = alu_result;

   // one cycle delayed copy
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk)
         data_bus_prev <= '0;
      else
         data_bus_prev <= data_bus;
   end

   // unit results feed back in, so this covers both units too
   a_bus_known: assert property (
      @(posedge rst_reg) disable iff (clk) !$isunknown(data_bus)
   );

endmodule

`default_nettype wire

//--- xdata_engine.f
xdata_pkg.sv
xconf_pkg.sv
xfu_if.sv
xinmux.sv
xmul.sv
xalu.sv
xconf_reg.sv
xdata_bus.sv
xdata_engine.sv
tb_xdata_engine.sv

//--- xdata_engine.sv
`timescale 1ns/10ps
`default_nettype none

module xdata_engine (
   input  logic                rst_reg,
   input  logic                clk,
   input  logic                in_we,
   input  xdata_pkg::data_t    in_a,
   input  xdata_pkg::data_t    in_b,
   input  logic                conf_we,
   input  logic                conf_addr,
   input  xconf_pkg::fu_conf_t conf_wdata,
   input  logic                conf_update,
   output xdata_pkg::data_t    mul_result,
   output xdata_pkg::data_t    alu_result
);
   import xdata_pkg::*;

   bus_t data_bus;
   bus_t data_bus_prev;

   xfu_if mul_if ();
   xfu_if alu_if ();

   xdata_bus i_xdata_bus (
      .rst_reg       (rst_reg),
      .clk           (clk),
      .in_we         (in_we),
      .in_a          (in_a),
      .in_b          (in_b),
      .mul_result    (mul_if.result),
      .alu_result    (alu_if.result),
      .data_bus      (data_bus),
      .data_bus_prev (data_bus_prev)
   );

   // same bus to both units
   assign mul_if.data_bus = data_bus;
   assign mul_if.data_bus_prev = data_bus_prev;
   assign alu_if.data_bus = data_bus;
   assign alu_if.data_bus_prev = data_bus_prev;

   xconf_reg i_xconf_reg (
      .rst_reg     (rst_reg),
      .clk         (clk),
      .conf_we     (conf_we),
      .conf_addr   (conf_addr),
      .conf_wdata  (conf_wdata),
      .conf_update (conf_update),
      .mul_conf    (mul_if.conf),
      .alu_conf    (alu_if.conf)
   );

   xmul i_xmul (
      .rst_reg (rst_reg),
      .clk     (clk),
      .fu      (mul_if.fu)
   );

   xalu i_xalu (
      .rst_reg (rst_reg),
      .clk     (clk),
      .fu      (alu_if.fu)
   );

   assign mul_result = mul_if.result;
   assign alu_result = alu_if.result;

endmodule

`default_nettype wire

//--- xdata_pkg.sv
`default_nettype none

package xdata_pkg;

   // data word width and number of bus entries
   localparam int DATA_W = 32;
   localparam int N = 4;

   // bus entry positions
   localparam int ENTRY_A = 0;
   localparam int ENTRY_B = 1;
   localparam int ENTRY_MUL = 2;
   localparam int ENTRY_ALU = 3;

   typedef logic signed [DATA_W-1:0] data_t;

   // full signed product
   typedef logic signed [2*DATA_W-1:0] prod_t;

   // entry 0 in the low word
   typedef logic [N*DATA_W-1:0] bus_t;

endpackage

`default_nettype wire

//--- xfu_if.sv
`timescale 1ns/10ps
`default_nettype none

interface xfu_if;
   import xdata_pkg::*;
   import xconf_pkg::*;

   bus_t     data_bus;
   bus_t     data_bus_prev;
   fu_conf_t conf;
   data_t    result;

   // functional unit side
   modport fu (
      input  data_bus,
      input  data_bus_prev,
      input  conf,
      output result
   );

   // engine side, bus and configuration in, result back
   modport eng (
      output data_bus,
      output data_bus_prev,
      output conf,
      input  result
   );

endinterface

`default_nettype wire

//--- xinmux.sv
`timescale 1ns/10ps
`default_nettype none

module xinmux (
   input  xconf_pkg::sel_t  sel,
   input  xdata_pkg::bus_t  data_bus,
   input  xdata_pkg::bus_t  data_bus_prev,
   output xdata_pkg::data_t data_out,
   output logic             enabled
);
   import xdata_pkg::*;
   import xconf_pkg::*;

   int idx;

   assign idx = int'(sel);

   always_comb begin
      data_out = '0;
      enabled = 1'b0;
      if (idx < N) begin
         data_out = data_bus[idx*DATA_W +: DATA_W];
         enabled = 1'b1;
      end else if (idx < 2*N) begin
         // previous cycle copy of the same entry
         data_out = data_bus_prev[(idx-N)*DATA_W +: DATA_W];
         enabled = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- xmul.sv
`timescale 1ns/10ps
`default_nettype none

module xmul (
   input logic rst_reg,
   input logic clk,
   xfu_if.fu   fu
);
   import xdata_pkg::*;
   import xconf_pkg::*;

   data_t   op_a;
   data_t   op_b;
   data_t   op_a_reg;
   data_t   op_b_reg;
   prod_t   prod_reg;
   data_t   res;
   logic    enablea;
   logic    enableb;
   logic    enabled;
   mul_fn_e fn;

   xinmux muxa (
      .sel           (conf_sela(fu.conf)),
      .data_bus      (fu.data_bus),
      .data_bus_prev (fu.data_bus_prev),
      .data_out      (op_a),
      .enabled       (enablea)
   );

   xinmux muxb (
      .sel           (conf_selb(fu.conf)),
      .data_bus      (fu.data_bus),
      .data_bus_prev (fu.data_bus_prev),
      .data_out      (op_b),
      .enabled       (enableb)
   );

   assign enabled = enablea & enableb;
   assign fn = mul_fn_e'(conf_fn(fu.conf));

   // operand and product stages
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
         prod_reg <= '0;
      end else begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
         prod_reg <= op_a_reg * op_b_reg;
      end
   end

   // result window
   always_comb begin
      case (fn)
         MUL_HI:      res = prod_reg[2*DATA_W-2 -: DATA_W];
         MUL_DIV2_HI: res = prod_reg[2*DATA_W-1 -: DATA_W];
         default:     res = prod_reg[DATA_W-1:0];
      endcase
   end

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk)
         fu.result <= '0;
      else if (enabled)
         fu.result <= res;
   end

   a_hold_when_disabled: assert property (
      @(posedge rst_reg) disable iff (clk) !enabled |=> $stable(fu.result)
   );

endmodule

`default_nettype wire
